//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_ooo_backend
FILELIST  = list.f
BUILD_DIR = obj_dir
PASS_MSG  = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- list.f
src/backend_pkg.sv
src/rename_stage.sv
src/phys_reg_file.sv
src/issue_stage.sv
src/alu_unit.sv
src/mul_unit.sv
src/div_unit.sv
src/ooo_backend.sv
test/tb_ooo_backend.sv

//--- src/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  backend_pkg::op_t   op,
    input  backend_pkg::data_t a,
    input  backend_pkg::data_t b,
    input  backend_pkg::seq_t  id,
    input  backend_pkg::preg_t pd,
    input  backend_pkg::preg_t old_pd,
    output logic               wb_en,
    output backend_pkg::preg_t wb_pd,
    output backend_pkg::data_t wb_data,
    output backend_pkg::seq_t  wb_id,
    output backend_pkg::preg_t wb_old_pd
);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            case (op)
                backend_pkg::ADD: wb_data <= a + b;
                backend_pkg::SUB: wb_data <= a - b;
                backend_pkg::AND: wb_data <= a & b;
                backend_pkg::OR:  wb_data <= a | b;
                backend_pkg::XOR: wb_data <= a ^ b;
                backend_pkg::SLL: wb_data <= a << b[4:0];  // shamt from low 5 bits
                default:          wb_data <= '0;
            endcase
            wb_pd     <= pd;
            wb_id     <= id;
            wb_old_pd <= old_pd;
        end
    end

endmodule

//--- src/backend_pkg.sv
package backend_pkg;

    localparam int NUM_AREGS   = 32;
    localparam int NUM_PREGS   = 128;
    localparam int FREE_DEPTH  = 96;    // pregs left after the identity map
    localparam int MUL_LATENCY = 3;
    localparam int DIV_CYCLES  = 33;    // load, 32 steps, then writeback

    typedef logic [31:0] data_t;
    typedef logic [4:0]  areg_t;
    typedef logic [6:0]  preg_t;
    typedef logic [7:0]  seq_t;         // carried through untouched

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        MUL,
        DIV,
        REM
    } op_t;

    // divider sequencing
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } div_state_t;

endpackage

//--- src/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  backend_pkg::op_t   op,
    input  backend_pkg::data_t a,
    input  backend_pkg::data_t b,
    input  backend_pkg::seq_t  id,
    input  backend_pkg::preg_t pd,
    input  backend_pkg::preg_t old_pd,
    output logic               busy,
    output logic               wb_en,
    output backend_pkg::preg_t wb_pd,
    output backend_pkg::data_t wb_data,
    output backend_pkg::seq_t  wb_id,
    output backend_pkg::preg_t wb_old_pd
);

    backend_pkg::div_state_t state;
    backend_pkg::data_t      quo;       // dividend shifts out as quotient shifts in
    backend_pkg::data_t      rem;
    backend_pkg::data_t      divisor;
    backend_pkg::seq_t       id_q;
    backend_pkg::preg_t      pd_q;
    backend_pkg::preg_t      old_pd_q;
    logic                    is_rem;
    logic [5:0]              step;
    logic [32:0]             rem_shift;
    logic [32:0]             rem_diff;

    assign rem_shift = {rem, quo[31]};
    assign rem_diff  = rem_shift - {1'b0, divisor};
    assign busy      = (state != backend_pkg::IDLE);
    assign wb_en     = (state == backend_pkg::DONE);
    assign wb_data   = is_rem ? rem : quo;      // final values held through DONE

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= backend_pkg::IDLE;
            step  <= '0;
        end else begin
            case (state)
                backend_pkg::IDLE: begin
                    if (start) begin
                        state <= backend_pkg::RUN;
                        step  <= '0;
                    end
                end
                backend_pkg::RUN: begin
                    step <= step + 6'd1;
                    if (step == 6'(backend_pkg::DIV_CYCLES - 2)) begin
                        state <= backend_pkg::DONE;     // last of 32 steps
                    end
                end
                default: begin
                    state <= backend_pkg::IDLE;
                end
            endcase
        end
    end

    // zero divisor always subtracts, leaving quotient all ones, remainder = dividend
    always_ff @(posedge clk) begin
        if (state == backend_pkg::IDLE && start) begin
            quo      <= a;
            rem      <= '0;
            divisor  <= b;
            is_rem   <= (op == backend_pkg::REM);
            id_q     <= id;
            pd_q     <= pd;
            old_pd_q <= old_pd;
        end else if (state == backend_pkg::RUN) begin
            if (!rem_diff[32]) begin
                rem <= rem_diff[31:0];
                quo <= {quo[30:0], 1'b1};
            end else begin
                rem <= rem_shift[31:0];
                quo <= {quo[30:0], 1'b0};
            end
        end
    end

    // tags stay put until the next start, which follows writeback
    assign wb_id     = id_q;
    assign wb_pd     = pd_q;
    assign wb_old_pd = old_pd_q;

    a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
        start |-> !busy);

endmodule

//--- src/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               ren_valid,
    input  backend_pkg::seq_t  ren_id,
    input  backend_pkg::op_t   ren_op,
    input  backend_pkg::preg_t ren_ps1,
    input  backend_pkg::preg_t ren_ps2,
    input  backend_pkg::preg_t ren_pd,
    input  backend_pkg::preg_t ren_old_pd,
    input  backend_pkg::data_t rf_data1,
    input  backend_pkg::data_t rf_data2,
    input  logic               rf_valid1,
    input  logic               rf_valid2,
    input  logic               rf_valid3,
    input  logic               div_busy,
    output logic               issue_full,
    output backend_pkg::preg_t rd_addr1,
    output backend_pkg::preg_t rd_addr2,
    output backend_pkg::preg_t rd_addr3,
    output logic               alu_start,
    output logic               mul_start,
    output logic               div_start,
    output backend_pkg::op_t   ex_op,
    output backend_pkg::data_t ex_a,
    output backend_pkg::data_t ex_b,
    output backend_pkg::seq_t  ex_id,
    output backend_pkg::preg_t ex_pd,
    output backend_pkg::preg_t ex_old_pd
);

    logic               slot_valid;
    backend_pkg::seq_t  slot_id;
    backend_pkg::op_t   slot_op;
    backend_pkg::preg_t slot_ps1;
    backend_pkg::preg_t slot_ps2;
    backend_pkg::preg_t slot_pd;
    backend_pkg::preg_t slot_old_pd;
    logic               is_mul;
    logic               is_div;
    logic               fire;

    assign is_mul = (slot_op == backend_pkg::MUL);
    assign is_div = (slot_op == backend_pkg::DIV) || (slot_op == backend_pkg::REM);

    // old_pd valid means every earlier user of the register is done
    assign fire = slot_valid && rf_valid1 && rf_valid2 && rf_valid3 &&
                  !(is_div && div_busy);
    assign issue_full = slot_valid && !fire;

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= 1'b0;
        end else if (!issue_full) begin
            slot_valid <= ren_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!issue_full) begin
            slot_id     <= ren_id;
            slot_op     <= ren_op;
            slot_ps1    <= ren_ps1;
            slot_ps2    <= ren_ps2;
            slot_pd     <= ren_pd;
            slot_old_pd <= ren_old_pd;
        end
    end

    assign rd_addr1  = slot_ps1;
    assign rd_addr2  = slot_ps2;
    assign rd_addr3  = slot_old_pd;

    assign alu_start = fire && !is_mul && !is_div;
    assign mul_start = fire && is_mul;
    assign div_start = fire && is_div;

    assign ex_op     = slot_op;
    assign ex_a      = rf_data1;    // operands read in the fire cycle
    assign ex_b      = rf_data2;
    assign ex_id     = slot_id;
    assign ex_pd     = slot_pd;
    assign ex_old_pd = slot_old_pd;

    a_one_start: assert property (@(posedge clk) disable iff (reset)
        $onehot0({alu_start, mul_start, div_start}));

endmodule

//--- src/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  backend_pkg::op_t   op,
    input  backend_pkg::data_t a,
    input  backend_pkg::data_t b,
    input  backend_pkg::seq_t  id,
    input  backend_pkg::preg_t pd,
    input  backend_pkg::preg_t old_pd,
    output logic               wb_en,
    output backend_pkg::preg_t wb_pd,
    output backend_pkg::data_t wb_data,
    output backend_pkg::seq_t  wb_id,
    output backend_pkg::preg_t wb_old_pd
);

    localparam int L = backend_pkg::MUL_LATENCY;

    logic [L-1:0]       vld;
    backend_pkg::seq_t  id_q     [L];
    backend_pkg::preg_t pd_q     [L];
    backend_pkg::preg_t old_pd_q [L];
    backend_pkg::data_t p1_lo;      // a * b[15:0], low word
    logic [15:0]        p1_hi;      // cross term, only low half reaches the result
    backend_pkg::data_t p2_sum;
    backend_pkg::data_t p3_prod;

    always_ff @(posedge clk) begin
        if (reset) begin
            vld <= '0;
        end else begin
            vld <= {vld[L-2:0], start};
        end
    end

    always_ff @(posedge clk) begin
        id_q[0]     <= id;
        pd_q[0]     <= pd;
        old_pd_q[0] <= old_pd;
        for (int i = 1; i < L; i++) begin
            id_q[i]     <= id_q[i-1];
            pd_q[i]     <= pd_q[i-1];
            old_pd_q[i] <= old_pd_q[i-1];
        end
        p1_lo   <= a * {16'b0, b[15:0]};
        p1_hi   <= a[15:0] * b[31:16];
        p2_sum  <= p1_lo + {p1_hi, 16'b0};
        p3_prod <= p2_sum;
    end

    assign wb_en     = vld[L-1];
    assign wb_id     = id_q[L-1];
    assign wb_pd     = pd_q[L-1];
    assign wb_old_pd = old_pd_q[L-1];
    assign wb_data   = p3_prod;

    a_mul_only: assert property (@(posedge clk) disable iff (reset)
        start |-> op == backend_pkg::MUL);

endmodule

//--- src/ooo_backend.sv
`timescale 1ns/1ps

module ooo_backend (
    input  logic               clk,
    input  logic               reset,
    input  logic               instr_valid,
    input  backend_pkg::seq_t  instr_id,
    input  backend_pkg::op_t   instr_op,
    input  backend_pkg::areg_t instr_rs1,
    input  backend_pkg::areg_t instr_rs2,
    input  backend_pkg::areg_t instr_rd,
    output logic               stall,
    output logic               alu_done,
    output backend_pkg::seq_t  alu_done_id,
    output backend_pkg::data_t alu_done_data,
    output logic               mul_done,
    output backend_pkg::seq_t  mul_done_id,
    output backend_pkg::data_t mul_done_data,
    output logic               div_done,
    output backend_pkg::seq_t  div_done_id,
    output backend_pkg::data_t div_done_data
);

    logic               alloc_en;
    backend_pkg::preg_t alloc_pd;
    logic               ren_valid;
    backend_pkg::seq_t  ren_id;
    backend_pkg::op_t   ren_op;
    backend_pkg::preg_t ren_ps1, ren_ps2, ren_pd, ren_old_pd;
    logic               issue_full;

    backend_pkg::preg_t rd_addr1, rd_addr2, rd_addr3;
    backend_pkg::data_t rf_data1, rf_data2;
    logic               rf_valid1, rf_valid2, rf_valid3;

    logic               alu_start, mul_start, div_start, div_busy;
    backend_pkg::op_t   ex_op;
    backend_pkg::data_t ex_a, ex_b;
    backend_pkg::seq_t  ex_id;
    backend_pkg::preg_t ex_pd, ex_old_pd;

    backend_pkg::preg_t alu_wb_pd, alu_wb_old_pd;
    backend_pkg::preg_t mul_wb_pd, mul_wb_old_pd;
    backend_pkg::preg_t div_wb_pd, div_wb_old_pd;

    rename_stage i_rename (
        .clk, .reset, .instr_valid, .instr_id, .instr_op, .instr_rs1, .instr_rs2,
        .instr_rd, .issue_full,
        .alu_free_en(alu_done), .alu_free_pd(alu_wb_old_pd),
        .mul_free_en(mul_done), .mul_free_pd(mul_wb_old_pd),
        .div_free_en(div_done), .div_free_pd(div_wb_old_pd),
        .stall, .alloc_en, .alloc_pd, .ren_valid, .ren_id, .ren_op,
        .ren_ps1, .ren_ps2, .ren_pd, .ren_old_pd
    );

    phys_reg_file i_prf (
        .clk, .reset, .rd_addr1, .rd_addr2, .rd_addr3, .alloc_en, .alloc_pd,
        .alu_wr_en(alu_done), .alu_wr_pd(alu_wb_pd), .alu_wr_data(alu_done_data),
        .mul_wr_en(mul_done), .mul_wr_pd(mul_wb_pd), .mul_wr_data(mul_done_data),
        .div_wr_en(div_done), .div_wr_pd(div_wb_pd), .div_wr_data(div_done_data),
        .rd_data1(rf_data1), .rd_data2(rf_data2),
        .rd_valid1(rf_valid1), .rd_valid2(rf_valid2), .rd_valid3(rf_valid3)
    );

    issue_stage i_issue (
        .clk, .reset, .ren_valid, .ren_id, .ren_op, .ren_ps1, .ren_ps2, .ren_pd,
        .ren_old_pd, .rf_data1, .rf_data2, .rf_valid1, .rf_valid2, .rf_valid3,
        .div_busy, .issue_full, .rd_addr1, .rd_addr2, .rd_addr3,
        .alu_start, .mul_start, .div_start,
        .ex_op, .ex_a, .ex_b, .ex_id, .ex_pd, .ex_old_pd
    );

    alu_unit i_alu (
        .clk, .reset, .start(alu_start), .op(ex_op), .a(ex_a), .b(ex_b),
        .id(ex_id), .pd(ex_pd), .old_pd(ex_old_pd),
        .wb_en(alu_done), .wb_pd(alu_wb_pd), .wb_data(alu_done_data),
        .wb_id(alu_done_id), .wb_old_pd(alu_wb_old_pd)
    );

    mul_unit i_mul (
        .clk, .reset, .start(mul_start), .op(ex_op), .a(ex_a), .b(ex_b),
        .id(ex_id), .pd(ex_pd), .old_pd(ex_old_pd),
        .wb_en(mul_done), .wb_pd(mul_wb_pd), .wb_data(mul_done_data),
        .wb_id(mul_done_id), .wb_old_pd(mul_wb_old_pd)
    );

    div_unit i_div (
        .clk, .reset, .start(div_start), .op(ex_op), .a(ex_a), .b(ex_b),
        .id(ex_id), .pd(ex_pd), .old_pd(ex_old_pd), .busy(div_busy),
        .wb_en(div_done), .wb_pd(div_wb_pd), .wb_data(div_done_data),
        .wb_id(div_done_id), .wb_old_pd(div_wb_old_pd)
    );

endmodule

//--- src/phys_reg_file.sv
`timescale 1ns/1ps

module phys_reg_file (
    input  logic               clk,
    input  logic               reset,
    input  backend_pkg::preg_t rd_addr1,
    input  backend_pkg::preg_t rd_addr2,
    input  backend_pkg::preg_t rd_addr3,
    input  logic               alloc_en,
    input  backend_pkg::preg_t alloc_pd,
    input  logic               alu_wr_en,
    input  backend_pkg::preg_t alu_wr_pd,
    input  backend_pkg::data_t alu_wr_data,
    input  logic               mul_wr_en,
    input  backend_pkg::preg_t mul_wr_pd,
    input  backend_pkg::data_t mul_wr_data,
    input  logic               div_wr_en,
    input  backend_pkg::preg_t div_wr_pd,
    input  backend_pkg::data_t div_wr_data,
    output backend_pkg::data_t rd_data1,
    output backend_pkg::data_t rd_data2,
    output logic               rd_valid1,
    output logic               rd_valid2,
    output logic               rd_valid3
);

    backend_pkg::data_t regs [backend_pkg::NUM_PREGS];
    logic [backend_pkg::NUM_PREGS-1:0] valid;

    backend_pkg::preg_t wr_pd   [3];
    backend_pkg::data_t wr_data [3];
    logic [2:0]         wr_en;

    // writes to p0 are dropped so it keeps reading zero
    assign wr_en      = {div_wr_en && div_wr_pd != '0,
                         mul_wr_en && mul_wr_pd != '0,
                         alu_wr_en && alu_wr_pd != '0};
    assign wr_pd[0]   = alu_wr_pd;
    assign wr_pd[1]   = mul_wr_pd;
    assign wr_pd[2]   = div_wr_pd;
    assign wr_data[0] = alu_wr_data;
    assign wr_data[1] = mul_wr_data;
    assign wr_data[2] = div_wr_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < backend_pkg::NUM_PREGS; i++) begin
                regs[i]  <= (i < backend_pkg::NUM_AREGS) ? backend_pkg::data_t'(i) : '0;
                valid[i] <= (i < backend_pkg::NUM_AREGS);
            end
        end else begin
            for (int k = 0; k < 3; k++) begin
                if (wr_en[k]) begin
                    regs[wr_pd[k]]  <= wr_data[k];
                    valid[wr_pd[k]] <= 1'b1;
                end
            end
            if (alloc_en && alloc_pd != '0) begin
                valid[alloc_pd] <= 1'b0;    // new producer pending
            end
        end
    end

    assign rd_data1  = regs[rd_addr1];
    assign rd_data2  = regs[rd_addr2];
    assign rd_valid1 = valid[rd_addr1];
    assign rd_valid2 = valid[rd_addr2];
    assign rd_valid3 = valid[rd_addr3];

    a_distinct_wr: assert property (@(posedge clk) disable iff (reset)
        !(wr_en[0] && wr_en[1] && wr_pd[0] == wr_pd[1]) &&
        !(wr_en[0] && wr_en[2] && wr_pd[0] == wr_pd[2]) &&
        !(wr_en[1] && wr_en[2] && wr_pd[1] == wr_pd[2]));

endmodule

//--- src/rename_stage.sv
`timescale 1ns/1ps

module rename_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               instr_valid,
    input  backend_pkg::seq_t  instr_id,
    input  backend_pkg::op_t   instr_op,
    input  backend_pkg::areg_t instr_rs1,
    input  backend_pkg::areg_t instr_rs2,
    input  backend_pkg::areg_t instr_rd,
    input  logic               issue_full,
    input  logic               alu_free_en,
    input  backend_pkg::preg_t alu_free_pd,
    input  logic               mul_free_en,
    input  backend_pkg::preg_t mul_free_pd,
    input  logic               div_free_en,
    input  backend_pkg::preg_t div_free_pd,
    output logic               stall,
    output logic               alloc_en,
    output backend_pkg::preg_t alloc_pd,
    output logic               ren_valid,
    output backend_pkg::seq_t  ren_id,
    output backend_pkg::op_t   ren_op,
    output backend_pkg::preg_t ren_ps1,
    output backend_pkg::preg_t ren_ps2,
    output backend_pkg::preg_t ren_pd,
    output backend_pkg::preg_t ren_old_pd
);

    backend_pkg::preg_t map_table [backend_pkg::NUM_AREGS];
    backend_pkg::preg_t free_mem  [backend_pkg::FREE_DEPTH];
    backend_pkg::preg_t push_pd   [3];

    logic [6:0] head;           // oldest free entry
    logic [6:0] tail;           // next slot to fill
    logic [6:0] count;
    logic [6:0] tail_next;
    logic [6:0] push_addr [3];
    logic [2:0] push_en;
    logic [1:0] push_cnt;
    logic       free_empty;
    logic       need_pd;
    logic       hold;
    logic       accept;
    logic       pop;

    function automatic logic [6:0] wrap_inc(input logic [6:0] p);
        return (p == 7'(backend_pkg::FREE_DEPTH - 1)) ? 7'd0 : p + 7'd1;
    endfunction

    // p0 never goes back on the list
    assign push_en    = {div_free_en && div_free_pd != '0,
                         mul_free_en && mul_free_pd != '0,
                         alu_free_en && alu_free_pd != '0};
    assign push_pd[0] = alu_free_pd;
    assign push_pd[1] = mul_free_pd;
    assign push_pd[2] = div_free_pd;
    assign push_cnt   = 2'(push_en[0]) + 2'(push_en[1]) + 2'(push_en[2]);

    assign free_empty = (count == '0);
    assign need_pd    = (instr_rd != '0);
    assign hold       = ren_valid && issue_full;
    assign stall      = hold || (free_empty && need_pd);
    assign accept     = instr_valid && !stall;
    assign pop        = accept && need_pd;
    assign alloc_en   = pop;
    assign alloc_pd   = free_mem[head];

    // pack the enabled pushes onto consecutive slots
    always_comb begin
        logic [6:0] p;
        p = tail;
        for (int k = 0; k < 3; k++) begin
            push_addr[k] = p;
            if (push_en[k]) begin
                p = wrap_inc(p);
            end
        end
        tail_next = p;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < backend_pkg::FREE_DEPTH; i++) begin
                free_mem[i] <= backend_pkg::preg_t'(backend_pkg::NUM_AREGS + i);
            end
            head  <= '0;
            tail  <= '0;        // full ring, tail meets head
            count <= 7'(backend_pkg::FREE_DEPTH);
        end else begin
            for (int k = 0; k < 3; k++) begin
                if (push_en[k]) begin
                    free_mem[push_addr[k]] <= push_pd[k];
                end
            end
            if (pop) begin
                head <= wrap_inc(head);
            end
            tail  <= tail_next;
            count <= count + 7'(push_cnt) - 7'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < backend_pkg::NUM_AREGS; i++) begin
                map_table[i] <= backend_pkg::preg_t'(i);
            end
        end else if (pop) begin
            map_table[instr_rd] <= alloc_pd;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ren_valid <= 1'b0;
        end else if (!hold) begin
            ren_valid <= accept;
        end
    end

    // x0 looks up p0 for both pd and old_pd
    always_ff @(posedge clk) begin
        if (accept) begin
            ren_id     <= instr_id;
            ren_op     <= instr_op;
            ren_ps1    <= map_table[instr_rs1];
            ren_ps2    <= map_table[instr_rs2];
            ren_pd     <= need_pd ? alloc_pd : '0;
            ren_old_pd <= map_table[instr_rd];
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> !free_empty);

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        count <= 7'(backend_pkg::FREE_DEPTH));

endmodule

//--- test/tb_ooo_backend.sv
`timescale 1ns/1ps

module tb_ooo_backend;

    // per test: reset 35, alu 88, chains 35, div by zero 6, random 400, waw/war 12
    localparam int NUM_INSTR       = 576;
    localparam int RANDOM_COUNT    = 400;
    localparam int WATCHDOG_CYCLES = NUM_INSTR * backend_pkg::DIV_CYCLES + 1000;

    logic               clk;
    logic               reset;
    logic               instr_valid;
    backend_pkg::seq_t  instr_id;
    backend_pkg::op_t   instr_op;
    backend_pkg::areg_t instr_rs1;
    backend_pkg::areg_t instr_rs2;
    backend_pkg::areg_t instr_rd;
    logic               stall;
    logic               alu_done;
    backend_pkg::seq_t  alu_done_id;
    backend_pkg::data_t alu_done_data;
    logic               mul_done;
    backend_pkg::seq_t  mul_done_id;
    backend_pkg::data_t mul_done_data;
    logic               div_done;
    backend_pkg::seq_t  div_done_id;
    backend_pkg::data_t div_done_data;

    backend_pkg::data_t model    [backend_pkg::NUM_AREGS];   // program-order arch state
    backend_pkg::data_t exp_data [256];
    logic [255:0]       pending;
    backend_pkg::seq_t  next_id;
    int                 instr_count;
    int                 done_count;
    int                 stall_cycles;   // back-pressure seen by the source

    ooo_backend i_dut (
        .clk, .reset, .instr_valid, .instr_id, .instr_op, .instr_rs1, .instr_rs2,
        .instr_rd, .stall,
        .alu_done, .alu_done_id, .alu_done_data,
        .mul_done, .mul_done_id, .mul_done_data,
        .div_done, .div_done_id, .div_done_data
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_done_error(input string unit, input backend_pkg::seq_t id,
                                     input backend_pkg::data_t data);
        report_error($sformatf("%s done id %0d data %h, expected %h, pending %b",
                               unit, id, data, exp_data[id], pending[id]));
    endtask

    // results as the ISA defines them, divide by zero included
    function automatic backend_pkg::data_t expected_result(input backend_pkg::op_t op,
                                                           input backend_pkg::data_t a,
                                                           input backend_pkg::data_t b);
        case (op)
            backend_pkg::ADD: return a + b;
            backend_pkg::SUB: return a - b;
            backend_pkg::AND: return a & b;
            backend_pkg::OR:  return a | b;
            backend_pkg::XOR: return a ^ b;
            backend_pkg::SLL: return a << b[4:0];
            backend_pkg::MUL: return a * b;
            backend_pkg::DIV: return (b == 32'd0) ? 32'hffff_ffff : a / b;
            backend_pkg::REM: return (b == 32'd0) ? a : a % b;
            default:          return 32'd0;
        endcase
    endfunction

    function automatic backend_pkg::areg_t rand_reg();
        return backend_pkg::areg_t'($urandom_range(31, 0));
    endfunction

    function automatic backend_pkg::op_t rand_op();
        return backend_pkg::op_t'(4'($urandom_range(8, 0)));
    endfunction

    // called at posedge + 1 ns, returns at posedge + 1 ns after acceptance
    task automatic send(input backend_pkg::op_t op, input backend_pkg::areg_t rs1,
                        input backend_pkg::areg_t rs2, input backend_pkg::areg_t rd);
        backend_pkg::data_t result;
        logic               accepted;
        while (pending[next_id]) begin  // id still in flight after wraparound
            @(posedge clk);
            #1;
        end
        result            = expected_result(op, model[rs1], model[rs2]);
        exp_data[next_id] = result;
        instr_valid       = 1'b1;
        instr_id          = next_id;
        instr_op          = op;
        instr_rs1         = rs1;
        instr_rs2         = rs2;
        instr_rd          = rd;
        accepted          = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = !stall;          // stable until the next edge
            @(posedge clk);
            #1;
        end
        if (rd != 5'd0) begin
            model[rd] = result;
        end
        next_id     = next_id + 8'd1;
        instr_count = instr_count + 1;
        instr_valid = 1'b0;
    endtask

    task automatic reset_contents_test();
        for (int i = 0; i < backend_pkg::NUM_AREGS; i++) begin
            send(backend_pkg::ADD, backend_pkg::areg_t'(i), 5'd0, backend_pkg::areg_t'(i));
        end
        send(backend_pkg::ADD, 5'd5, 5'd6, 5'd0);    // x0 write dropped
        send(backend_pkg::ADD, 5'd0, 5'd0, 5'd1);
        send(backend_pkg::ADD, 5'd0, 5'd2, 5'd2);
    endtask

    task automatic alu_ops_test();
        backend_pkg::op_t mix_op;
        for (int k = 0; k < 40; k++) begin
            case ($urandom_range(3, 0))
                0:       mix_op = backend_pkg::MUL;
                1:       mix_op = backend_pkg::XOR;
                2:       mix_op = backend_pkg::SLL;
                default: mix_op = backend_pkg::ADD;
            endcase
            send(mix_op, rand_reg(), rand_reg(), backend_pkg::areg_t'($urandom_range(31, 1)));
        end
        for (int op = 0; op < 6; op++) begin
            for (int k = 0; k < 8; k++) begin
                send(backend_pkg::op_t'(4'(op)), rand_reg(), rand_reg(), rand_reg());
            end
        end
    endtask

    task automatic dependency_chain_test();
        backend_pkg::areg_t ra;
        backend_pkg::areg_t rb;
        backend_pkg::areg_t rc;
        for (int k = 0; k < 5; k++) begin
            ra = backend_pkg::areg_t'($urandom_range(31, 1));
            rb = backend_pkg::areg_t'($urandom_range(31, 1));
            rc = backend_pkg::areg_t'($urandom_range(31, 1));
            send(backend_pkg::DIV, rand_reg(), rb, ra);
            send(backend_pkg::MUL, ra, ra, rb);
            send(backend_pkg::ADD, rb, ra, ra);
            send(backend_pkg::DIV, ra, rc, rc);
            send(backend_pkg::REM, rc, rb, rb);
            send(backend_pkg::MUL, rb, rc, rc);
            send(backend_pkg::ADD, rc, rb, ra);
        end
    endtask

    task automatic divide_by_zero_test();
        send(backend_pkg::DIV, 5'd9, 5'd0, 5'd15);
        send(backend_pkg::REM, 5'd9, 5'd0, 5'd16);
        send(backend_pkg::SUB, 5'd4, 5'd4, 5'd17);   // x17 becomes zero
        send(backend_pkg::DIV, 5'd21, 5'd17, 5'd18);
        send(backend_pkg::REM, 5'd21, 5'd17, 5'd19);
        send(backend_pkg::DIV, 5'd0, 5'd0, 5'd20);
    endtask

    task automatic recycling_test();
        int sent;
        sent = 0;
        while (sent < RANDOM_COUNT) begin
            if ($urandom_range(7, 0) == 0 && sent <= RANDOM_COUNT - 2) begin
                send(backend_pkg::DIV, rand_reg(), rand_reg(), rand_reg());
                send(backend_pkg::DIV, rand_reg(), rand_reg(), rand_reg());
                sent = sent + 2;
            end else begin
                send(rand_op(), rand_reg(), rand_reg(), rand_reg());
                sent = sent + 1;
            end
        end
    endtask

    task automatic waw_war_test();
        backend_pkg::areg_t rd;
        for (int k = 0; k < 3; k++) begin
            rd = backend_pkg::areg_t'(8 + k);
            send(backend_pkg::DIV, 5'd30, 5'd2, rd);        // slow producer
            send(backend_pkg::ADD, 5'd1, 5'd2, rd);         // fast overwrite
            send(backend_pkg::ADD, rd, 5'd0, 5'd12);        // reader sees the ADD
            send(backend_pkg::MUL, 5'd12, 5'd3, rd);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            pending      <= '0;
            done_count   <= 0;
            stall_cycles <= 0;
        end else begin
            if (alu_done) pending[alu_done_id] <= 1'b0;
            if (mul_done) pending[mul_done_id] <= 1'b0;
            if (div_done) pending[div_done_id] <= 1'b0;
            if (instr_valid && !stall) pending[instr_id] <= 1'b1;
            if (stall) stall_cycles <= stall_cycles + 1;
            done_count <= done_count + int'(alu_done) + int'(mul_done) + int'(div_done);
        end
    end

    a_reset_idle: assert property (@(posedge clk)
        $fell(reset) |-> !stall && !alu_done && !mul_done && !div_done)
        else report_error("stall or a done strobe was high right after reset");

    a_alu_done: assert property (@(posedge clk) disable iff (reset)
        alu_done |-> pending[alu_done_id] && alu_done_data == exp_data[alu_done_id])
        else report_done_error("alu", $sampled(alu_done_id), $sampled(alu_done_data));

    a_mul_done: assert property (@(posedge clk) disable iff (reset)
        mul_done |-> pending[mul_done_id] && mul_done_data == exp_data[mul_done_id])
        else report_done_error("mul", $sampled(mul_done_id), $sampled(mul_done_data));

    a_div_done: assert property (@(posedge clk) disable iff (reset)
        div_done |-> pending[div_done_id] && div_done_data == exp_data[div_done_id])
        else report_done_error("div", $sampled(div_done_id), $sampled(div_done_data));

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run hung, %0d of %0d instructions done",
                 done_count, instr_count);
        $display("Some tests failed");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'h48671b39));
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr_id    = '0;
        instr_op    = backend_pkg::ADD;
        instr_rs1   = '0;
        instr_rs2   = '0;
        instr_rd    = '0;
        next_id     = '0;
        instr_count = 0;
        for (int i = 0; i < backend_pkg::NUM_AREGS; i++) begin
            model[i] = backend_pkg::data_t'(i);
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        reset_contents_test();
        alu_ops_test();
        dependency_chain_test();
        divide_by_zero_test();
        recycling_test();
        waw_war_test();

        while (done_count < instr_count) begin
            @(posedge clk);
        end
        repeat (50) @(posedge clk);     // catch any late duplicate
        if (pending != '0 || done_count != instr_count || stall_cycles == 0) begin
            report_error($sformatf("%0d of %0d instructions done, pending left %b, %0d stall cycles",
                                   done_count, instr_count, pending != '0, stall_cycles));
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule
